/* include/mod_macros.svh */
`ifndef MOD_MACROS_SVH
`define MOD_MACROS_SVH

// ********************
// Segment and datapath sizes
// ********************

`define MOD_NUM_SEGMENT 2
`define MOD_TIME_W 56
`define MOD_DIVIDEND_W 48  // System time without its low 8 bits
`define MOD_DIVISOR_W 16

// ********************
// Pipeline latencies
// ********************

`define MOD_DIV_LATENCY (`MOD_DIVIDEND_W + 2)  // Input register, one stage per bit, output register
`define MOD_UPDATE_LATENCY (2 * `MOD_DIV_LATENCY + 2)

`define MOD_AXI_ADDR_W 8

`endif

/* hw/mod_pkg.sv */
`include "mod_macros.svh"

package mod_pkg;

  typedef logic [`MOD_TIME_W-1:0] sys_time_t;
  typedef logic [14:0] seg_cycle_t;  // Last index of the cycle, the length is this plus one
  typedef logic [`MOD_DIVISOR_W-1:0] freq_div_t;
  typedef logic [14:0] mod_idx_t;

  typedef enum logic {
    IDLE,
    LOAD
  } timer_state_e;

  // ********************
  // Register map
  // ********************

  typedef enum logic [7:0] {
    CTRL      = 8'h00,
    STATUS    = 8'h04,
    CYCLE0    = 8'h10,
    FREQ_DIV0 = 8'h14,
    CYCLE1    = 8'h18,
    FREQ_DIV1 = 8'h1C
  } reg_offset_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

endpackage

/* hw/pipe_divider.sv */
`timescale 1ns/100ps
`include "mod_macros.svh"

module pipe_divider (
  input  logic                       CLK,
  input  logic                       arst_n,
  input  logic [`MOD_DIVIDEND_W-1:0] dividend,
  input  mod_pkg::freq_div_t         divisor,
  input  logic                       valid_in,
  output logic [`MOD_DIVIDEND_W-1:0] quotient,
  output logic [`MOD_DIVISOR_W-1:0]  remainder,
  output logic                       valid_out
);

  localparam int DW = `MOD_DIVIDEND_W;
  localparam int VW = `MOD_DIVISOR_W;

  // Index 0 is the input register, index s holds the state after stage s
  logic [DW-1:0] dq_q  [DW+1];  // Unconsumed dividend bits on top, quotient bits shifted in below
  logic [VW-1:0] rem_q [1:DW];
  logic [VW-1:0] dvs_q [DW];
  logic [DW:0]   vld_q;

  logic [DW-1:0] dq_d  [1:DW];
  logic [VW-1:0] rem_d [1:DW];

  // ********************
  // Restoring stages
  // ********************

  for (genvar s = 1; s <= DW; s++) begin : gen_stage
    logic [VW-1:0] rem_in;
    logic [VW:0]   trial;
    logic [VW:0]   diff;
    logic          fits;

    if (s == 1) begin : gen_first
      assign rem_in = '0;  // Each division starts from a zero partial remainder
    end else begin : gen_next
      assign rem_in = rem_q[s-1];
    end

    assign trial = {rem_in, dq_q[s-1][DW-1]};
    assign diff  = trial - {1'b0, dvs_q[s-1]};
    assign fits  = trial >= {1'b0, dvs_q[s-1]};  // Always set for a zero divisor

    assign rem_d[s] = fits ? diff[VW-1:0] : trial[VW-1:0];
    assign dq_d[s]  = {dq_q[s-1][DW-2:0], fits};
  end

  always_ff @(posedge CLK) begin
    dq_q[0]  <= dividend;
    dvs_q[0] <= divisor;
    for (int s = 1; s <= DW; s++) begin
      dq_q[s]  <= dq_d[s];
      rem_q[s] <= rem_d[s];
    end
    for (int s = 1; s < DW; s++) begin
      dvs_q[s] <= dvs_q[s-1];  // Each pair keeps its own divisor while in flight
    end
    quotient  <= dq_q[DW];
    remainder <= rem_q[DW];
  end

  // ********************
  // Valid pipeline
  // ********************

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      vld_q     <= '0;
      valid_out <= 1'b0;
    end else begin
      vld_q     <= {vld_q[DW-1:0], valid_in};
      valid_out <= vld_q[DW];
    end
  end

  // Only checked once the pipeline has run out of reset for a full latency
  a_valid_latency : assert property (
    @(posedge CLK) disable iff (!arst_n)
    $past(arst_n, `MOD_DIV_LATENCY) |-> (valid_out == $past(valid_in, `MOD_DIV_LATENCY))
  );

endmodule

/* hw/modulation_timer.sv */
`timescale 1ns/100ps
`include "mod_macros.svh"

module modulation_timer (
  input  logic                CLK,
  input  logic                arst_n,
  input  mod_pkg::sys_time_t  sys_time,
  input  mod_pkg::seg_cycle_t cycle    [`MOD_NUM_SEGMENT],
  input  mod_pkg::freq_div_t  freq_div [`MOD_NUM_SEGMENT],
  input  logic                update_req,
  output mod_pkg::mod_idx_t   idx      [`MOD_NUM_SEGMENT],
  output logic                busy,
  output logic                settings_updated
);

  import mod_pkg::*;

  localparam int CNT_W = $clog2(`MOD_UPDATE_LATENCY);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MOD_UPDATE_LATENCY - 2);

  timer_state_e     state;
  logic [CNT_W-1:0] cnt;
  logic             accept;

  assign accept = (state == IDLE) && update_req;  // Requests during LOAD are dropped
  assign busy   = (state == LOAD);

  // ********************
  // Per-segment index
  // ********************

  for (genvar i = 0; i < `MOD_NUM_SEGMENT; i++) begin : gen_segment
    freq_div_t                  freq_div_q;
    logic [`MOD_DIVISOR_W-1:0]  cycle_len_q;
    logic [`MOD_DIVIDEND_W-1:0] cnt_quo;
    logic                       cnt_valid;
    logic [`MOD_DIVISOR_W-1:0]  idx_rem;
    logic                       idx_valid;
    mod_idx_t                   idx_q;

    always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
        freq_div_q  <= 16'd1;
        cycle_len_q <= 16'd1;
        idx_q       <= '0;
      end else begin
        if (accept) begin
          freq_div_q  <= freq_div[i];
          cycle_len_q <= {1'b0, cycle[i]} + 1'b1;
        end
        if (idx_valid) begin
          idx_q <= idx_rem[$bits(mod_idx_t)-1:0];  // Remainder is below the cycle length
        end
      end
    end

    assign idx[i] = idx_q;

    pipe_divider div_cnt (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .dividend  (sys_time[`MOD_TIME_W-1:`MOD_TIME_W-`MOD_DIVIDEND_W]),
      .divisor   (freq_div_q),
      .valid_in  (1'b1),
      .quotient  (cnt_quo),
      .remainder (),
      .valid_out (cnt_valid)
    );

    pipe_divider div_idx (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .dividend  (cnt_quo),
      .divisor   (cycle_len_q),
      .valid_in  (cnt_valid),
      .quotient  (),
      .remainder (idx_rem),
      .valid_out (idx_valid)
    );
  end

  // ********************
  // Update sequence
  // ********************

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state            <= IDLE;
      cnt              <= '0;
      settings_updated <= 1'b0;
    end else begin
      settings_updated <= 1'b0;
      case (state)
        IDLE: begin
          cnt <= '0;
          if (accept) begin
            state <= LOAD;
          end
        end
        LOAD: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_LAST) begin  // Both dividers now carry the new settings
            settings_updated <= 1'b1;
            state            <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_done_one_cycle : assert property (
    @(posedge CLK) disable iff (!arst_n)
    settings_updated |=> !settings_updated
  );

  a_done_on_exit : assert property (
    @(posedge CLK) disable iff (!arst_n)
    settings_updated |-> (state == IDLE) && ($past(state) == LOAD)
  );

endmodule

/* hw/mod_regs.sv */
`timescale 1ns/100ps
`include "mod_macros.svh"

module mod_regs (
  input  logic                       CLK,
  input  logic                       arst_n,
  input  logic [`MOD_AXI_ADDR_W-1:0] awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [31:0]                wdata,
  input  logic [3:0]                 wstrb,
  input  logic                       wvalid,
  output logic                       wready,
  output mod_pkg::axi_resp_e         bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  logic [`MOD_AXI_ADDR_W-1:0] araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [31:0]                rdata,
  output mod_pkg::axi_resp_e         rresp,
  output logic                       rvalid,
  input  logic                       rready,
  output mod_pkg::seg_cycle_t        cycle    [`MOD_NUM_SEGMENT],
  output mod_pkg::freq_div_t         freq_div [`MOD_NUM_SEGMENT],
  output logic                       update_req,
  input  logic                       busy,
  input  logic                       settings_updated
);

  import mod_pkg::*;

  seg_cycle_t  cycle_q    [`MOD_NUM_SEGMENT];
  freq_div_t   freq_div_q [`MOD_NUM_SEGMENT];
  logic [15:0] cyc_new    [`MOD_NUM_SEGMENT];
  logic [15:0] div_new    [`MOD_NUM_SEGMENT];
  logic        done_q;
  logic        wr_fire;
  logic        rd_fire;
  axi_resp_e   wr_resp;
  axi_resp_e   rd_resp;
  logic [31:0] rd_data;

  function automatic logic [15:0] merge_half(logic [15:0] old_val, logic [31:0] data,
                                             logic [3:0] strb);
    logic [15:0] res;
    res = old_val;
    if (strb[0]) begin
      res[7:0] = data[7:0];
    end
    if (strb[1]) begin
      res[15:8] = data[15:8];
    end
    return res;
  endfunction

  for (genvar i = 0; i < `MOD_NUM_SEGMENT; i++) begin : gen_seg
    assign cyc_new[i]  = merge_half({1'b0, cycle_q[i]}, wdata, wstrb);
    assign div_new[i]  = merge_half(freq_div_q[i], wdata, wstrb);
    assign cycle[i]    = cycle_q[i];
    assign freq_div[i] = freq_div_q[i];
  end

  // ********************
  // Write channel
  // ********************

  assign wr_fire = awvalid && wvalid && !bvalid;  // Address and data are taken together
  assign awready = wr_fire;
  assign wready  = wr_fire;

  always_comb begin
    case (reg_offset_e'(awaddr))
      CTRL, STATUS, CYCLE0, CYCLE1: wr_resp = OKAY;
      FREQ_DIV0: wr_resp = (div_new[0] == '0) ? SLVERR : OKAY;
      FREQ_DIV1: wr_resp = (div_new[1] == '0) ? SLVERR : OKAY;
      default:   wr_resp = SLVERR;
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `MOD_NUM_SEGMENT; i++) begin
        cycle_q[i]    <= '0;
        freq_div_q[i] <= 16'd1;
      end
      done_q     <= 1'b0;
      update_req <= 1'b0;
      bvalid     <= 1'b0;
    end else begin
      update_req <= 1'b0;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (wr_fire) begin
        bvalid <= 1'b1;
        case (reg_offset_e'(awaddr))
          CTRL: begin
            update_req <= wstrb[0] && wdata[0];
            done_q     <= 1'b0;
          end
          CYCLE0: cycle_q[0] <= cyc_new[0][14:0];
          CYCLE1: cycle_q[1] <= cyc_new[1][14:0];
          FREQ_DIV0: begin
            if (wr_resp == OKAY) begin
              freq_div_q[0] <= div_new[0];
            end
          end
          FREQ_DIV1: begin
            if (wr_resp == OKAY) begin
              freq_div_q[1] <= div_new[1];
            end
          end
          default: done_q <= done_q;
        endcase
      end
      if (settings_updated) begin
        done_q <= 1'b1;  // A completion beats a clear in the same cycle
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_fire) begin
      bresp <= wr_resp;
    end
  end

  // ********************
  // Read channel
  // ********************

  assign rd_fire = arvalid && !rvalid;
  assign arready = rd_fire;

  always_comb begin
    rd_data = '0;
    rd_resp = OKAY;
    case (reg_offset_e'(araddr))
      CTRL:      rd_data = '0;
      STATUS:    rd_data = {30'd0, done_q, busy};
      CYCLE0:    rd_data = {17'd0, cycle_q[0]};
      FREQ_DIV0: rd_data = {16'd0, freq_div_q[0]};
      CYCLE1:    rd_data = {17'd0, cycle_q[1]};
      FREQ_DIV1: rd_data = {16'd0, freq_div_q[1]};
      default:   rd_resp = SLVERR;
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (rd_fire) begin
      rdata <= rd_data;
      rresp <= rd_resp;
    end
  end

  a_bvalid_hold : assert property (
    @(posedge CLK) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable(bresp)
  );

endmodule

/* hw/mod_subsystem.sv */
`timescale 1ns/100ps
`include "mod_macros.svh"

module mod_subsystem (
  input  logic                       CLK,
  input  logic                       arst_n,
  input  logic [`MOD_AXI_ADDR_W-1:0] awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [31:0]                wdata,
  input  logic [3:0]                 wstrb,
  input  logic                       wvalid,
  output logic                       wready,
  output mod_pkg::axi_resp_e         bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  logic [`MOD_AXI_ADDR_W-1:0] araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [31:0]                rdata,
  output mod_pkg::axi_resp_e         rresp,
  output logic                       rvalid,
  input  logic                       rready,
  input  mod_pkg::sys_time_t         sys_time,
  output mod_pkg::mod_idx_t          idx [`MOD_NUM_SEGMENT],
  output logic                       settings_updated
);

  import mod_pkg::*;

  seg_cycle_t cycle    [`MOD_NUM_SEGMENT];
  freq_div_t  freq_div [`MOD_NUM_SEGMENT];
  logic       update_req;
  logic       busy;

  mod_regs mod_regs_inst (
    .CLK              (CLK),
    .arst_n           (arst_n),
    .awaddr           (awaddr),
    .awvalid          (awvalid),
    .awready          (awready),
    .wdata            (wdata),
    .wstrb            (wstrb),
    .wvalid           (wvalid),
    .wready           (wready),
    .bresp            (bresp),
    .bvalid           (bvalid),
    .bready           (bready),
    .araddr           (araddr),
    .arvalid          (arvalid),
    .arready          (arready),
    .rdata            (rdata),
    .rresp            (rresp),
    .rvalid           (rvalid),
    .rready           (rready),
    .cycle            (cycle),
    .freq_div         (freq_div),
    .update_req       (update_req),
    .busy             (busy),
    .settings_updated (settings_updated)
  );

  modulation_timer modulation_timer_inst (
    .CLK              (CLK),
    .arst_n           (arst_n),
    .sys_time         (sys_time),
    .cycle            (cycle),
    .freq_div         (freq_div),
    .update_req       (update_req),
    .idx              (idx),
    .busy             (busy),
    .settings_updated (settings_updated)
  );

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 5
) (
  output logic CLK,
  output logic arst_n
);

  initial begin
    CLK    = 1'b0;
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;  // Released between edges so no flop sees it move with the clock
  end

  always #HALF_PERIOD CLK = ~CLK;

endmodule

/* test/tb_mod_subsystem.sv */
`timescale 1ns/100ps
`include "mod_macros.svh"

module tb_mod_subsystem;

  import mod_pkg::*;

  localparam int IDX_LAT  = 2 * `MOD_DIV_LATENCY + 1;
  localparam int WATCHDOG = 40 * `MOD_UPDATE_LATENCY + 2000;

  logic        CLK;
  logic        arst_n;
  logic [7:0]  awaddr;
  logic [7:0]  araddr;
  logic        awvalid, wvalid, bready, arvalid, rready;
  logic        awready, wready, bvalid, arready, rvalid;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic [3:0]  wstrb;
  axi_resp_e   bresp;
  axi_resp_e   rresp;
  sys_time_t   sys_time;
  mod_idx_t    idx [`MOD_NUM_SEGMENT];
  logic        settings_updated;

  int         cyc = 0;
  int         write_cycle;
  sys_time_t  time_hist [128];  // System time seen in each recent cycle
  freq_div_t  set_div   [`MOD_NUM_SEGMENT];
  seg_cycle_t set_cycle [`MOD_NUM_SEGMENT];

  tb_clock_gen clock_gen_inst (.CLK(CLK), .arst_n(arst_n));

  mod_subsystem mod_subsystem_inst (.*);

  always @(posedge CLK) cyc <= cyc + 1;
  always @(negedge CLK) time_hist[cyc & 127] = sys_time;

  // ********************
  // Checks and bus tasks
  // ********************

  task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic ensure(input bit ok, input string what);
    assert (ok) else begin
      $display("Error: %s", what);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output axi_resp_e resp);
    @(posedge CLK);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= 4'hf;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    @(negedge CLK);
    while (!(awready && wready)) @(negedge CLK);
    @(posedge CLK);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge CLK);
    write_cycle = cyc;  // Cycle in which a CTRL write raises update_req
    while (!bvalid) @(negedge CLK);
    resp = bresp;
    @(posedge CLK);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output axi_resp_e resp);
    @(posedge CLK);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    @(negedge CLK);
    while (!arready) @(negedge CLK);
    @(posedge CLK);
    arvalid <= 1'b0;
    @(negedge CLK);
    while (!rvalid) @(negedge CLK);
    data = rdata;
    resp = rresp;
    @(posedge CLK);
    rready <= 1'b0;
  endtask

  task automatic write_expect(input string name, input logic [7:0] addr,
                              input logic [31:0] data, input axi_resp_e exp_resp);
    axi_resp_e resp;
    axi_write(addr, data, resp);
    compare_value({name, " bresp"}, exp_resp, resp);
  endtask

  task automatic read_expect(input string name, input logic [7:0] addr,
                             input logic [31:0] exp_data, input axi_resp_e exp_resp);
    logic [31:0] data;
    axi_resp_e   resp;
    axi_read(addr, data, resp);
    compare_value({name, " rresp"}, exp_resp, resp);
    compare_value({name, " rdata"}, exp_data, data);
  endtask

  function automatic logic [7:0] cycle_addr(input int seg);
    return (seg == 0) ? CYCLE0 : CYCLE1;
  endfunction

  function automatic logic [7:0] div_addr(input int seg);
    return (seg == 0) ? FREQ_DIV0 : FREQ_DIV1;
  endfunction

  task automatic wait_for_update(output int at);
    int n;
    n = 0;
    @(negedge CLK);
    while (!settings_updated && n < 2 * `MOD_UPDATE_LATENCY) begin
      @(negedge CLK);
      n++;
    end
    ensure(settings_updated, "settings_updated never pulsed after an update request");
    at = cyc;
  endtask

  // Time in units of 256 ticks, scaled by the divider, wrapped on the cycle length
  function automatic mod_idx_t expected_index(input sys_time_t t, input freq_div_t fdiv,
                                              input seg_cycle_t last);
    logic [47:0] count;
    logic [47:0] len;
    count = t[55:8] / {32'd0, fdiv};
    len   = {33'd0, last} + 48'd1;
    return mod_idx_t'(count % len);
  endfunction

  task automatic run_index_window(input string name, input int cycles);
    logic [63:0] jump;
    for (int n = 0; n < cycles; n++) begin
      jump = {$urandom, $urandom};
      @(posedge CLK);
      if (n % 37 == 36) begin
        sys_time <= jump[55:0];
      end else begin
        sys_time <= sys_time + 56'd256;
      end
      @(negedge CLK);
      for (int s = 0; s < `MOD_NUM_SEGMENT; s++) begin
        compare_value(name, expected_index(time_hist[(cyc - IDX_LAT) & 127], set_div[s],
                                           set_cycle[s]), idx[s]);
      end
    end
  endtask

  // ********************
  // Directed tests
  // ********************

  task automatic register_access();
    logic [31:0] val;
    for (int s = 0; s < `MOD_NUM_SEGMENT; s++) begin
      compare_value("register_access reset idx", 32'd0, idx[s]);
    end
    compare_value("register_access reset settings_updated", 32'd0, settings_updated);
    read_expect("register_access reset CTRL", CTRL, 32'd0, OKAY);
    read_expect("register_access reset STATUS", STATUS, 32'd0, OKAY);
    for (int s = 0; s < `MOD_NUM_SEGMENT; s++) begin
      read_expect("register_access reset CYCLE", cycle_addr(s), 32'd0, OKAY);
      read_expect("register_access reset FREQ_DIV", div_addr(s), 32'd1, OKAY);
      val = $urandom & 32'h7fff;
      write_expect("register_access write CYCLE", cycle_addr(s), val, OKAY);
      read_expect("register_access read CYCLE", cycle_addr(s), val, OKAY);
      val = $urandom_range(65535, 1);
      write_expect("register_access write FREQ_DIV", div_addr(s), val, OKAY);
      read_expect("register_access read FREQ_DIV", div_addr(s), val, OKAY);
    end
  endtask

  task automatic error_responses();
    logic [31:0] old;
    axi_resp_e   resp;
    write_expect("error_responses unmapped write 0x08", 8'h08, 32'h1234, SLVERR);
    write_expect("error_responses unmapped write 0x40", 8'h40, 32'h5678, SLVERR);
    axi_read(8'h0c, old, resp);
    compare_value("error_responses unmapped read rresp", SLVERR, resp);
    for (int s = 0; s < `MOD_NUM_SEGMENT; s++) begin
      axi_read(div_addr(s), old, resp);
      write_expect("error_responses zero FREQ_DIV", div_addr(s), 32'd0, SLVERR);
      read_expect("error_responses FREQ_DIV kept", div_addr(s), old, OKAY);
    end
  endtask

  task automatic update_sequence();
    int req;
    int at;
    write_expect("update_sequence CTRL", CTRL, 32'd1, OKAY);
    req = write_cycle;
    read_expect("update_sequence STATUS busy", STATUS, 32'd1, OKAY);
    wait_for_update(at);
    compare_value("update_sequence latency", `MOD_UPDATE_LATENCY, at - req);
    read_expect("update_sequence STATUS done", STATUS, 32'd2, OKAY);
  endtask

  task automatic index_computation();
    int at;
    for (int r = 0; r < 3; r++) begin
      for (int s = 0; s < `MOD_NUM_SEGMENT; s++) begin
        if (r == 0) begin
          set_div[s]   = freq_div_t'(s + 1);
          set_cycle[s] = seg_cycle_t'(4 + 3 * s);
        end else if (r == 1) begin
          set_div[s]   = freq_div_t'($urandom_range(16, 1));
          set_cycle[s] = seg_cycle_t'($urandom_range(300, 0));
        end else begin
          set_div[s]   = freq_div_t'($urandom_range(65535, 1));
          set_cycle[s] = seg_cycle_t'($urandom);
        end
        write_expect("index_computation CYCLE", cycle_addr(s), {17'd0, set_cycle[s]}, OKAY);
        write_expect("index_computation FREQ_DIV", div_addr(s), {16'd0, set_div[s]}, OKAY);
      end
      write_expect("index_computation CTRL", CTRL, 32'd1, OKAY);
      wait_for_update(at);
      run_index_window("index_computation idx", 300);
    end
  endtask

  task automatic deferred_request();
    int first;
    int pulses;
    int at;
    pulses = 0;
    at     = 0;
    write_expect("deferred_request first CTRL", CTRL, 32'd1, OKAY);
    first = write_cycle;
    repeat (20) @(posedge CLK);
    read_expect("deferred_request STATUS busy", STATUS, 32'd1, OKAY);
    write_expect("deferred_request second CTRL", CTRL, 32'd1, OKAY);
    for (int n = 0; n < 2 * `MOD_UPDATE_LATENCY; n++) begin  // Long enough to see a late pulse
      @(negedge CLK);
      if (settings_updated) begin
        pulses++;
        at = cyc;
      end
    end
    compare_value("deferred_request pulse count", 32'd1, pulses);
    compare_value("deferred_request latency", `MOD_UPDATE_LATENCY, at - first);
    read_expect("deferred_request STATUS done", STATUS, 32'd2, OKAY);
  endtask

  initial begin
    logic [63:0] start_time;
    void'($urandom(32'hcab0_cf73));
    start_time = {$urandom, $urandom};
    awaddr   <= '0;
    awvalid  <= 1'b0;
    wdata    <= '0;
    wstrb    <= '0;
    wvalid   <= 1'b0;
    bready   <= 1'b0;
    araddr   <= '0;
    arvalid  <= 1'b0;
    rready   <= 1'b0;
    sys_time <= start_time[55:0];
    @(posedge arst_n);
    register_access();
    error_responses();
    update_sequence();
    index_computation();
    deferred_request();
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG) @(posedge CLK);
    $display("Error: the tests did not finish within %0d clock cycles", WATCHDOG);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* list.f */
+incdir+include
hw/mod_pkg.sv
hw/pipe_divider.sv
hw/modulation_timer.sv
hw/mod_regs.sv
hw/mod_subsystem.sv
test/tb_clock_gen.sv
test/tb_mod_subsystem.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module tb_mod_subsystem \
  --Mdir obj_dir -o tb_mod_subsystem \
  && ./obj_dir/tb_mod_subsystem \
  || { echo "run_sim: build or simulation error"; exit 1; }
